/* logic/i2c_slave_pkg.sv */
package i2c_slave_pkg;

	//////////////////////////////
	// Device and register file
	//////////////////////////////

	// Own 7-bit slave address
	localparam logic [6:0] dev_addr = 7'h42;

	// Register file depth and pointer width
	localparam int reg_count = 16;
	localparam int ptr_width = 4;

	// Data byte width
	localparam int byte_width = 8;

	//////////////////////////////
	// Shared types
	//////////////////////////////

	typedef logic [byte_width-1:0] byte_t;
	typedef logic [ptr_width-1:0] reg_ptr_t;

	// Synchronized line events, pulses except sda_level
	typedef struct packed {
		logic scl_rise;
		logic scl_fall;
		logic start_det;
		logic stop_det;
		logic sda_level;
	} line_events_t;

	// Controller to serializer
	typedef struct packed {
		logic load;
		byte_t data;
		logic ack_req;
	} ser_cmd_t;

	// Register file write port
	typedef struct packed {
		logic en;
		reg_ptr_t addr;
		byte_t data;
	} reg_wr_t;

endpackage

/* logic/i2c_line_sync.sv */
module i2c_line_sync
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input logic scl,
	input logic sda_in,
	output line_events_t events
);

	// Two-stage synchronizers, bit 1 is the safe copy
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;
	// Previous synchronized levels for edge compare
	logic scl_q;
	logic sda_q;

	//////////////////////////////
	// Synchronizer and edge stage
	//////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			// Idle bus is high on both lines
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			events <= '{scl_rise: 1'b0, scl_fall: 1'b0, start_det: 1'b0,
				stop_det: 1'b0, sda_level: 1'b1};
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda_in};
			scl_q <= scl_sync[1];
			sda_q <= sda_sync[1];
			// SCL edges
			events.scl_rise <= scl_sync[1] & ~scl_q;
			events.scl_fall <= ~scl_sync[1] & scl_q;
			// SDA fall with SCL held high
			events.start_det <= scl_sync[1] & scl_q & ~sda_sync[1] & sda_q;
			// SDA rise with SCL held high
			events.stop_det <= scl_sync[1] & scl_q & sda_sync[1] & ~sda_q;
			events.sda_level <= sda_sync[1];
		end
	end

	// SDA holds still across every SCL edge
	assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		(scl_sync[1] != scl_q) |-> (sda_sync[1] == sda_q))
		else $error("SDA changed together with SCL");

endmodule

/* logic/i2c_deserializer.sv */
module i2c_deserializer
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input line_events_t events,
	output byte_t rx_byte,
	output logic rx_valid,
	output logic ack_bit,
	output logic ack_valid
);

	// SCL rising edges seen in the current nine-bit frame
	logic [3:0] bit_cnt;
	// Bits collected so far, MSB first
	byte_t shift_q;

	//////////////////////////////
	// Frame bit counter
	//////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			bit_cnt <= '0;
		end
		else if (events.start_det || events.stop_det)
		begin
			// Any bus condition starts a new frame
			bit_cnt <= '0;
		end
		else if (events.scl_rise)
		begin
			// Ninth edge closes the frame
			if (bit_cnt == 4'd8)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 4'd1;
		end
	end

	//////////////////////////////
	// Data and ACK capture
	//////////////////////////////

	// Payload shift register
	always_ff @(posedge Clock)
	begin
		if (events.scl_rise && bit_cnt < 4'd8)
		begin
			shift_q <= {shift_q[byte_width-2:0], events.sda_level};
		end
	end

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			rx_byte <= '0;
			rx_valid <= 1'b0;
			ack_bit <= 1'b1;
			ack_valid <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			rx_valid <= 1'b0;
			ack_valid <= 1'b0;
			if (events.scl_rise && !events.start_det && !events.stop_det)
			begin
				// Eighth bit completes the byte
				if (bit_cnt == 4'd7)
				begin
					rx_byte <= {shift_q[byte_width-2:0], events.sda_level};
					rx_valid <= 1'b1;
				end
				// Ninth bit is the ACK slot, low means ACK
				else if (bit_cnt == 4'd8)
				begin
					ack_bit <= events.sda_level;
					ack_valid <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/i2c_serializer.sv */
module i2c_serializer
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input line_events_t events,
	input ser_cmd_t ser_cmd,
	output logic sda_drive_low
);

	// ACK requested, waiting for the next SCL fall
	logic ack_arm;
	// Byte loaded, first bit goes out at the next SCL fall
	logic data_pend;
	// Bits already placed on the bus, 8 means byte done
	logic [3:0] bit_cnt;
	byte_t data_q;

	//////////////////////////////
	// Output shifter
	//////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			ack_arm <= 1'b0;
			data_pend <= 1'b0;
			bit_cnt <= '0;
			sda_drive_low <= 1'b0;
		end
		else if (events.start_det || events.stop_det)
		begin
			// Bus condition, release everything
			ack_arm <= 1'b0;
			data_pend <= 1'b0;
			bit_cnt <= '0;
			sda_drive_low <= 1'b0;
		end
		else if (ser_cmd.load)
		begin
			data_pend <= 1'b1;
			bit_cnt <= '0;
		end
		else if (events.scl_fall)
		begin
			if (ack_arm)
			begin
				// Pull low for one full SCL period
				sda_drive_low <= 1'b1;
				ack_arm <= 1'b0;
			end
			else if (data_pend)
			begin
				// MSB leaves as the ACK slot ends
				sda_drive_low <= ~data_q[byte_width-1];
				data_pend <= 1'b0;
				bit_cnt <= 4'd1;
			end
			else if (bit_cnt != 4'd0 && bit_cnt < 4'd8)
			begin
				sda_drive_low <= ~data_q[byte_width-1];
				bit_cnt <= bit_cnt + 4'd1;
			end
			else
			begin
				// End of ACK drive, or byte done and master answers
				sda_drive_low <= 1'b0;
				bit_cnt <= '0;
			end
		end
		else if (ser_cmd.ack_req)
		begin
			ack_arm <= 1'b1;
		end
	end

	// Outgoing byte, MSB always at the top
	always_ff @(posedge Clock)
	begin
		if (ser_cmd.load)
			data_q <= ser_cmd.data;
		else if (events.scl_fall && (data_pend || (bit_cnt != 4'd0 && bit_cnt < 4'd8)))
			data_q <= {data_q[byte_width-2:0], 1'b0};
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Master ACK slot opens with nothing queued to drive
	assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		(events.scl_fall && bit_cnt == 4'd8) |-> !(ack_arm || data_pend))
		else $error("slave would drive SDA in master ACK slot");

	// Controller never asks for both in one cycle
	assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		!(ser_cmd.load && ser_cmd.ack_req))
		else $error("load and ack_req together");

endmodule

/* logic/i2c_slave_ctrl.sv */
module i2c_slave_ctrl
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input line_events_t events,
	input byte_t rx_byte,
	input logic rx_valid,
	input logic ack_bit,
	input logic ack_valid,
	input byte_t rd_data,
	output ser_cmd_t ser_cmd,
	output reg_wr_t reg_wr,
	output reg_ptr_t rd_ptr
);

	typedef enum logic [2:0] {
		st_idle,
		st_addr,
		st_ptr,
		st_write,
		st_read,
		st_ignore
	} state_t;

	state_t state;
	// Register pointer, survives across transactions
	reg_ptr_t ptr;

	assign rd_ptr = ptr;

	//////////////////////////////
	// Transaction FSM
	//////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			state <= st_idle;
			ptr <= '0;
			ser_cmd <= '0;
			reg_wr <= '0;
		end
		else
		begin
			// Strobes default low
			ser_cmd.load <= 1'b0;
			ser_cmd.ack_req <= 1'b0;
			reg_wr.en <= 1'b0;
			if (events.start_det)
			begin
				// Also covers repeated START
				state <= st_addr;
			end
			else if (events.stop_det)
			begin
				state <= st_idle;
			end
			else
			begin
				case (state)
					st_addr:
					begin
						if (rx_valid)
						begin
							if (rx_byte[7:1] == dev_addr)
							begin
								ser_cmd.ack_req <= 1'b1;
								// R/W bit picks the direction
								state <= rx_byte[0] ? st_read : st_ptr;
							end
							else
							begin
								state <= st_ignore;
							end
						end
					end
					st_ptr:
					begin
						// First write byte is the pointer
						if (rx_valid)
						begin
							ptr <= rx_byte[ptr_width-1:0];
							ser_cmd.ack_req <= 1'b1;
							state <= st_write;
						end
					end
					st_write:
					begin
						if (rx_valid)
						begin
							ser_cmd.ack_req <= 1'b1;
							reg_wr.en <= 1'b1;
							reg_wr.addr <= ptr;
							reg_wr.data <= rx_byte;
							// Natural wrap at reg_count
							ptr <= ptr + 1'b1;
						end
					end
					st_read:
					begin
						// Own address ACK or master ACK, send next byte
						if (ack_valid)
						begin
							if (!ack_bit)
							begin
								ser_cmd.load <= 1'b1;
								ser_cmd.data <= rd_data;
								ptr <= ptr + 1'b1;
							end
							else
							begin
								// NACK ends the read, wait for STOP
								state <= st_ignore;
							end
						end
					end
					st_ignore:
					begin
						// Only START or STOP leaves
						state <= st_ignore;
					end
					default:
					begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

/* logic/i2c_reg_file.sv */
module i2c_reg_file
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input reg_wr_t reg_wr,
	input reg_ptr_t rd_ptr,
	output byte_t rd_data
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	byte_t regs [reg_count];

	// Synchronous write, all registers clear on reset
	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			for (int i = 0; i < reg_count; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (reg_wr.en)
		begin
			regs[reg_wr.addr] <= reg_wr.data;
		end
	end

	// Combinational read port
	assign rd_data = regs[rd_ptr];

endmodule

/* logic/i2c_slave_top.sv */
module i2c_slave_top
	import i2c_slave_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input logic scl,
	input logic sda_in,
	output logic sda_drive_low
);

	// Internal connections
	line_events_t events;
	byte_t rx_byte;
	logic rx_valid;
	logic ack_bit;
	logic ack_valid;
	ser_cmd_t ser_cmd;
	reg_wr_t reg_wr;
	reg_ptr_t rd_ptr;
	byte_t rd_data;

	//////////////////////////////
	// Bus front end
	//////////////////////////////

	i2c_line_sync u_i2c_line_sync (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.scl(scl),
		.sda_in(sda_in),
		.events(events)
	);

	i2c_deserializer u_i2c_deserializer (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.events(events),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.ack_bit(ack_bit),
		.ack_valid(ack_valid)
	);

	// Open-drain output, drive-low enable only
	i2c_serializer u_i2c_serializer (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.events(events),
		.ser_cmd(ser_cmd),
		.sda_drive_low(sda_drive_low)
	);

	//////////////////////////////
	// Control and storage
	//////////////////////////////

	i2c_slave_ctrl u_i2c_slave_ctrl (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.events(events),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.ack_bit(ack_bit),
		.ack_valid(ack_valid),
		.rd_data(rd_data),
		.ser_cmd(ser_cmd),
		.reg_wr(reg_wr),
		.rd_ptr(rd_ptr)
	);

	i2c_reg_file u_i2c_reg_file (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.reg_wr(reg_wr),
		.rd_ptr(rd_ptr),
		.rd_data(rd_data)
	);

endmodule

/* dv/i2c_bus_tasks.svh */
`ifndef i2c_bus_tasks_svh
`define i2c_bus_tasks_svh

//////////////////////////////
// Bit-level I2C master
//////////////////////////////

// Wait n cycles, every drive lands on a falling Clock edge
task automatic wait_clocks(input int n);
	repeat (n) @(negedge Clock);
endtask

// One SCL period starting from SCL low
// SDA moves in the low phase, sample in the middle of the high phase
task automatic clock_bit(input logic drive, output logic sampled);
	wait_clocks(scl_quarter);
	sda_drv = drive;
	wait_clocks(scl_half - scl_quarter);
	scl_drv = 1'b1;
	wait_clocks(scl_quarter);
	sampled = bus_sda;
	wait_clocks(scl_half - scl_quarter);
	scl_drv = 1'b0;
endtask

// START from idle, or repeated START from SCL low
task automatic start_condition();
	wait_clocks(scl_quarter);
	sda_drv = 1'b1;
	wait_clocks(scl_half - scl_quarter);
	scl_drv = 1'b1;
	wait_clocks(scl_half);
	// SDA falls with SCL high
	sda_drv = 1'b0;
	wait_clocks(scl_half);
	scl_drv = 1'b0;
endtask

// STOP from SCL low, bus left idle
task automatic stop_condition();
	wait_clocks(scl_quarter);
	sda_drv = 1'b0;
	wait_clocks(scl_half - scl_quarter);
	scl_drv = 1'b1;
	wait_clocks(scl_half);
	// SDA rises with SCL high
	sda_drv = 1'b1;
	wait_clocks(scl_half);
endtask

// First nbits of a byte, MSB first, no ACK slot
task automatic write_bits(input byte_t data, input int nbits);
	byte_t shreg;
	logic unused_bit;
	shreg = data;
	for (int i = 0; i < nbits; i++)
	begin
		clock_bit(shreg[7], unused_bit);
		shreg = {shreg[6:0], 1'b0};
	end
endtask

// Full byte plus ACK slot, acked when the slave pulled SDA low
task automatic write_byte(input byte_t data, output logic acked);
	logic ack_level;
	write_bits(data, 8);
	// Master lets go of SDA for the ACK
	clock_bit(1'b1, ack_level);
	acked = !ack_level;
endtask

// Byte from the slave, then master ACK (0) or NACK (1)
task automatic read_byte(input logic nack, output byte_t data);
	logic b;
	data = '0;
	for (int i = 0; i < 8; i++)
	begin
		clock_bit(1'b1, b);
		data = {data[6:0], b};
	end
	clock_bit(nack, b);
endtask

`endif

/* dv/i2c_slave_tb.sv */
module i2c_slave_tb
	import i2c_slave_pkg::*;
();

	// SCL half period in Clock cycles
	localparam int scl_half = 10;
	localparam int scl_quarter = scl_half / 2;
	localparam logic [31:0] rand_seed = 32'haa52_9f0c;
	// Roughly 1000 SCL periods over all tests, doubled for margin
	localparam int test_bits = 1000;
	localparam int timeout_cycles = 2 * test_bits * 2 * scl_half;
	// Neighbour of the own address, nobody answers
	localparam logic [6:0] other_addr = 7'h43;

	logic Clock;
	logic i2c_scl_neg_pulse;
	logic scl_drv;
	logic sda_drv;
	logic bus_sda;
	logic sda_drive_low;

	// Reference register file and pointer
	byte_t ref_regs [reg_count];
	reg_ptr_t ref_ptr;

	int value_errors;
	int ack_errors;
	int bus_errors;
	int drive_low_cycles;
	int cycle_cnt;
	logic [31:0] rnd_word;

	// Open-drain line, wired-AND of master and slave
	assign bus_sda = sda_drv & ~sda_drive_low;

	i2c_slave_top u_i2c_slave_top (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.scl(scl_drv),
		.sda_in(bus_sda),
		.sda_drive_low(sda_drive_low)
	);

	`include "i2c_bus_tasks.svh"

	//////////////////////////////
	// Clock, watchdog, monitors
	//////////////////////////////

	initial
	begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles)
		begin
			@(posedge Clock);
			cycle_cnt++;
		end
		$display("Timeout: tests still running after %0d cycles", cycle_cnt);
		$display("Errors found");
		$finish;
	end

	// Cycles with the slave pulling SDA low
	always @(posedge Clock)
	begin
		if (i2c_scl_neg_pulse)
			drive_low_cycles <= 0;
		else if (sda_drive_low)
			drive_low_cycles <= drive_low_cycles + 1;
	end

	//////////////////////////////
	// Checks and reference model
	//////////////////////////////

	task automatic compare_byte(input string name, input byte_t exp, input byte_t got);
		assert (got == exp)
		else
		begin
			$display("FAIL %s: expected %02h, actual %02h", name, exp, got);
			value_errors++;
		end
	endtask

	task automatic expect_ack(input string name, input string what, input logic exp,
		input logic got);
		assert (got == exp)
		else
		begin
			if (exp)
				$display("%s: slave did not ACK the %s", name, what);
			else
				$display("%s: slave ACKed the %s, it should have stayed silent", name, what);
			ack_errors++;
		end
	endtask

	task automatic bus_quiet(input string name, input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("%s: %s", name, what);
			bus_errors++;
		end
	endtask

	function automatic byte_t random_byte();
		logic [31:0] word;
		word = $urandom;
		return word[7:0];
	endfunction

	// Pointer byte then count random bytes, pointer wraps 15 to 0
	task automatic write_regs(input string name, input reg_ptr_t start_ptr, input int count);
		logic acked;
		byte_t data;
		start_condition();
		write_byte({dev_addr, 1'b0}, acked);
		expect_ack(name, "write address", 1'b1, acked);
		write_byte({4'h0, start_ptr}, acked);
		expect_ack(name, "pointer byte", 1'b1, acked);
		ref_ptr = start_ptr;
		for (int i = 0; i < count; i++)
		begin
			data = random_byte();
			write_byte(data, acked);
			expect_ack(name, "data byte", 1'b1, acked);
			ref_regs[ref_ptr] = data;
			ref_ptr = ref_ptr + 4'd1;
		end
		stop_condition();
	endtask

	task automatic read_open(input string name);
		logic acked;
		start_condition();
		write_byte({dev_addr, 1'b1}, acked);
		expect_ack(name, "read address", 1'b1, acked);
	endtask

	// Bytes from the current pointer, NACK on the last one
	task automatic read_data(input string name, input int count);
		byte_t got;
		for (int i = 0; i < count; i++)
		begin
			read_byte(i == count - 1, got);
			compare_byte(name, ref_regs[ref_ptr], got);
			ref_ptr = ref_ptr + 4'd1;
		end
	endtask

	task automatic read_regs(input string name, input int count);
		read_open(name);
		read_data(name, count);
		stop_condition();
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic reset_values();
		wait_clocks(1);
		bus_quiet("reset_values", !sda_drive_low, "sda_drive_low is high right after reset");
		// All 16 from pointer 0, all zero
		read_regs("reset_values", reg_count);
	endtask

	task automatic write_readback();
		write_regs("write_readback", 4'd3, 5);
		write_regs("write_readback", 4'd3, 0);
		read_regs("write_readback", 5);
	endtask

	task automatic pointer_wrap();
		// Lands in 14, 15, 0, 1
		write_regs("pointer_wrap", 4'd14, 4);
		// Read carries on at 2
		read_regs("pointer_wrap", 2);
		write_regs("pointer_wrap", 4'd14, 0);
		read_regs("pointer_wrap", 4);
	endtask

	task automatic wrong_address();
		logic acked;
		int drive_before;
		drive_before = drive_low_cycles;
		start_condition();
		write_byte({other_addr, 1'b0}, acked);
		expect_ack("wrong_address", "foreign address", 1'b0, acked);
		write_byte(8'h00, acked);
		expect_ack("wrong_address", "pointer byte", 1'b0, acked);
		for (int i = 0; i < 2; i++)
		begin
			write_byte(random_byte(), acked);
			expect_ack("wrong_address", "data byte", 1'b0, acked);
		end
		stop_condition();
		bus_quiet("wrong_address", drive_low_cycles == drive_before,
			"slave pulled SDA low during a foreign transaction");
		// No register may have moved
		write_regs("wrong_address", 4'd0, 0);
		read_regs("wrong_address", reg_count);
	endtask

	task automatic read_end();
		byte_t got;
		int drive_before;
		write_regs("read_end", 4'd14, 0);
		read_open("read_end");
		read_data("read_end", 2);
		drive_before = drive_low_cycles;
		// Master keeps clocking after its NACK
		read_byte(1'b1, got);
		bus_quiet("read_end", got == 8'hff && drive_low_cycles == drive_before,
			"slave still drives SDA after the master NACK");
		stop_condition();
		// Fresh transaction after STOP
		write_regs("read_end", 4'd7, 1);
		write_regs("read_end", 4'd7, 0);
		read_regs("read_end", 1);
	endtask

	task automatic abort_write();
		logic acked;
		write_regs("abort_write", 4'd9, 1);
		start_condition();
		write_byte({dev_addr, 1'b0}, acked);
		expect_ack("abort_write", "write address", 1'b1, acked);
		write_byte(8'h09, acked);
		expect_ack("abort_write", "pointer byte", 1'b1, acked);
		ref_ptr = 4'd9;
		// Half a byte then STOP, register 9 keeps its value
		write_bits(~ref_regs[9], 4);
		stop_condition();
		read_regs("abort_write", 1);
		write_regs("abort_write", 4'd9, 2);
		write_regs("abort_write", 4'd9, 0);
		read_regs("abort_write", 2);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		rnd_word = $urandom(rand_seed);
		scl_drv = 1'b1;
		sda_drv = 1'b1;
		i2c_scl_neg_pulse = 1'b1;
		value_errors = 0;
		ack_errors = 0;
		bus_errors = 0;
		ref_regs = '{default: '0};
		ref_ptr = '0;
		repeat (5) @(negedge Clock);
		i2c_scl_neg_pulse = 1'b0;

		reset_values();
		write_readback();
		pointer_wrap();
		wrong_address();
		read_end();
		abort_write();

		wait_clocks(scl_half);
		$display("Error counts: value %0d, ACK %0d, bus %0d", value_errors, ack_errors,
			bus_errors);
		if (value_errors + ack_errors + bus_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* files.f */
+incdir+dv
logic/i2c_slave_pkg.sv
logic/i2c_line_sync.sv
logic/i2c_deserializer.sv
logic/i2c_serializer.sv
logic/i2c_slave_ctrl.sv
logic/i2c_reg_file.sv
logic/i2c_slave_top.sv
dv/i2c_slave_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the I2C slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=i2c_slave_sim
log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module i2c_slave_tb \
	-Mdir "$build_dir" -o "$sim_exe"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Errors found" "$log_file"; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
exit 0
